// File: gba_timer_pkg.sv
package gba_timer_pkg;

    // port widths and default channel count.
    localparam int ADDR_W     = 4;
    localparam int DATA_W     = 16;
    localparam int NUM_TIMERS = 4;

    // interrupt flag register.
    localparam logic [ADDR_W-1:0] IF_ADDR = 4'd8;

    // prescaler ratio select, as written to the control half.
    typedef enum logic [1:0] {
        div_1    = 2'd0,
        div_64   = 2'd1,
        div_256  = 2'd2,
        div_1024 = 2'd3
    } prescale_t;

    // one strobe per ratio, bit order follows prescale_t.
    typedef struct packed {
        logic tick_1024;
        logic tick_256;
        logic tick_64;
        logic tick_1;
    } tick_t;

    // control half of one channel, occupies bits [4:0].
    typedef struct packed {
        logic      start;
        logic      irq_en;
        logic      count_up;
        prescale_t prescale;
    } timer_ctrl_t;

    localparam int CTRL_W = $bits(timer_ctrl_t);

    // reload on write, live count on read.
    function automatic logic [ADDR_W-1:0] TM_CNT_L_ADDR(input int n);
        return ADDR_W'(2 * n);
    endfunction

    function automatic logic [ADDR_W-1:0] TM_CNT_H_ADDR(input int n);
        return ADDR_W'(2 * n + 1);
    endfunction

endpackage

// File: timer_prescaler.sv
`timescale 1ns/100ps

module timer_prescaler (
    input  logic                  clock_16,
    input  logic                  reset,
    output gba_timer_pkg::tick_t  ticks
);

    // one shared divider for all channels, as on the console.
    logic [9:0] div_cnt;

    always_ff @(posedge clock_16) begin
        if (reset) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 10'd1; // free running, wraps at 1024.
        end
    end

    // a ratio fires when its low counter bits are all ones.
    always_comb begin
        ticks           = '0;
        ticks.tick_1    = 1'b1;
        ticks.tick_64   = &div_cnt[5:0];
        ticks.tick_256  = &div_cnt[7:0];
        ticks.tick_1024 = &div_cnt[9:0];
    end

endmodule

// File: timer.sv
`timescale 1ns/100ps

module timer (
    input  logic                        clock_16,
    input  logic                        reset,
    input  gba_timer_pkg::tick_t        ticks,
    input  logic [15:0]                 reload,
    input  gba_timer_pkg::timer_ctrl_t  ctrl,
    input  logic                        cascade_in,
    output logic [15:0]                 count,
    output logic                        overflow
);

    logic        start_q;    // start bit seen on the previous edge.
    logic        start_rise;
    logic        running;
    logic [3:0]  tick_bits;
    logic        tick_sel;
    logic        advance;

    assign start_rise = ctrl.start & ~start_q;

    // counting begins on the edge after the reload load.
    assign running = ctrl.start & start_q;

    // strobe for the selected ratio.
    assign tick_bits = ticks;
    assign tick_sel  = tick_bits[ctrl.prescale];

    // count-up mode follows the channel below instead of the prescaler.
    assign advance = ctrl.count_up ? cascade_in : tick_sel;

    assign overflow = running & advance & (count == 16'hFFFF);

    always_ff @(posedge clock_16) begin
        if (reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= ctrl.start;
        end
    end

    always_ff @(posedge clock_16) begin
        if (reset) begin
            count <= '0;
        end else if (start_rise) begin
            count <= reload;             // fresh start loads immediately.
        end else if (overflow) begin
            count <= reload;             // wrap reloads on the same edge.
        end else if (running && advance) begin
            count <= count + 16'd1;
        end
    end

endmodule

// File: timer_regs.sv
`timescale 1ns/100ps

module timer_regs #(
    parameter int NUM_TIMERS = gba_timer_pkg::NUM_TIMERS
) (
    input  logic                                         clock_16,
    input  logic                                         reset,
    input  logic                                         io_wr,
    input  logic [gba_timer_pkg::ADDR_W-1:0]             io_addr,
    input  logic [gba_timer_pkg::DATA_W-1:0]             io_wdata,
    output logic [gba_timer_pkg::DATA_W-1:0]             io_rdata,
    output logic [NUM_TIMERS-1:0][15:0]                  reloads,
    output gba_timer_pkg::timer_ctrl_t [NUM_TIMERS-1:0]  ctrls,
    input  logic [NUM_TIMERS-1:0][15:0]                  counts,
    input  logic [NUM_TIMERS-1:0]                        flags,
    output logic [NUM_TIMERS-1:0]                        flag_clear
);

    localparam int CTRL_W = gba_timer_pkg::CTRL_W;

    gba_timer_pkg::timer_ctrl_t wr_ctrl;

    // control bits as they arrive on the bus.
    assign wr_ctrl = gba_timer_pkg::timer_ctrl_t'(io_wdata[CTRL_W-1:0]);

    always_ff @(posedge clock_16) begin
        if (reset) begin
            reloads <= '0;
            ctrls   <= '0;
        end else if (io_wr) begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                if (io_addr == gba_timer_pkg::TM_CNT_L_ADDR(i)) begin
                    reloads[i] <= io_wdata;  // live count is untouched.
                end
                if (io_addr == gba_timer_pkg::TM_CNT_H_ADDR(i)) begin
                    ctrls[i] <= wr_ctrl;
                    // channel 0 has no lower neighbour to count from.
                    if (i == 0) begin
                        ctrls[i].count_up <= 1'b0;
                    end
                end
            end
        end
    end

    // write-1-to-clear mask, valid only in the write cycle.
    always_comb begin
        flag_clear = '0;
        if (io_wr && io_addr == gba_timer_pkg::IF_ADDR) begin
            flag_clear = io_wdata[NUM_TIMERS-1:0];
        end
    end

    // read mux; unmapped addresses return zero.
    always_comb begin
        io_rdata = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (io_addr == gba_timer_pkg::TM_CNT_L_ADDR(i)) begin
                io_rdata = counts[i];
            end
            if (io_addr == gba_timer_pkg::TM_CNT_H_ADDR(i)) begin
                io_rdata[CTRL_W-1:0] = ctrls[i];
            end
        end
        if (io_addr == gba_timer_pkg::IF_ADDR) begin
            io_rdata[NUM_TIMERS-1:0] = flags;
        end
    end

endmodule

// File: timer_irq.sv
`timescale 1ns/100ps

module timer_irq #(
    parameter int NUM_TIMERS = gba_timer_pkg::NUM_TIMERS
) (
    input  logic                   clock_16,
    input  logic                   reset,
    input  logic [NUM_TIMERS-1:0]  overflows,
    input  logic [NUM_TIMERS-1:0]  irq_en,
    input  logic [NUM_TIMERS-1:0]  flag_clear,
    output logic [NUM_TIMERS-1:0]  flags,
    output logic                   irq
);

    logic [NUM_TIMERS-1:0] flag_set;

    // only enabled channels raise a request.
    assign flag_set = overflows & irq_en;

    always_ff @(posedge clock_16) begin
        if (reset) begin
            flags <= '0;
        end else begin
            // set wins over a clear on the same edge.
            flags <= (flags & ~flag_clear) | flag_set;
        end
    end

    assign irq = |flags; // one combined line to the cpu.

endmodule

// File: timer_top.sv
`timescale 1ns/100ps

module timer_top #(
    parameter int NUM_TIMERS = gba_timer_pkg::NUM_TIMERS
) (
    input  logic                              clock_16,
    input  logic                              reset,
    input  logic                              io_wr,
    input  logic [gba_timer_pkg::ADDR_W-1:0]  io_addr,
    input  logic [gba_timer_pkg::DATA_W-1:0]  io_wdata,
    output logic [gba_timer_pkg::DATA_W-1:0]  io_rdata,
    output logic                              irq
);

    gba_timer_pkg::tick_t                        ticks;
    logic [NUM_TIMERS-1:0][15:0]                 reloads;
    gba_timer_pkg::timer_ctrl_t [NUM_TIMERS-1:0] ctrls;
    logic [NUM_TIMERS-1:0][15:0]                 counts;
    logic [NUM_TIMERS-1:0]                       overflows;
    logic [NUM_TIMERS-1:0]                       cascade;
    logic [NUM_TIMERS-1:0]                       irq_en;
    logic [NUM_TIMERS-1:0]                       flags;
    logic [NUM_TIMERS-1:0]                       flag_clear;

    timer_prescaler prescaler_i (
        .clock_16,
        .reset,
        .ticks
    );

    timer_regs #(.NUM_TIMERS(NUM_TIMERS)) regs_i (
        .clock_16,
        .reset,
        .io_wr,
        .io_addr,
        .io_wdata,
        .io_rdata,
        .reloads,
        .ctrls,
        .counts,
        .flags,
        .flag_clear
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_chan
        // each channel counts overflows of the one below it.
        if (i == 0) begin : g_first
            assign cascade[i] = 1'b0;
        end else begin : g_chain
            assign cascade[i] = overflows[i-1];
        end

        assign irq_en[i] = ctrls[i].irq_en;

        timer timer_i (
            .clock_16,
            .reset,
            .ticks,
            .reload     (reloads[i]),
            .ctrl       (ctrls[i]),
            .cascade_in (cascade[i]),
            .count      (counts[i]),
            .overflow   (overflows[i])
        );
    end

    timer_irq #(.NUM_TIMERS(NUM_TIMERS)) irq_i (
        .clock_16,
        .reset,
        .overflows,
        .irq_en,
        .flag_clear,
        .flags,
        .irq
    );

endmodule

// File: tb_timer_top.sv
`timescale 1ns/100ps

module tb_timer_top;

    localparam int NUM_TIMERS   = 4;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int WINDOWS      = 4;   // 64 cycle windows in the prescaler test.

    // cycle budget per test, summed for the watchdog.
    localparam int T1_CYCLES     = 20;
    localparam int T2_CYCLES     = 300;
    localparam int T3_CYCLES     = 10 + (WINDOWS + 1) * 64;
    localparam int T4_CYCLES     = 260;
    localparam int T5_CYCLES     = 120;
    localparam int T6_CYCLES     = 160;
    localparam int TEST_CYCLES   = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                   T4_CYCLES + T5_CYCLES + T6_CYCLES;
    localparam int MARGIN_CYCLES = 1000;

    // control half bits: prescale [1:0], count_up 2, irq_en 3, start 4.
    localparam logic [15:0] CTRL_DIV_64   = 16'h0001;
    localparam logic [15:0] CTRL_COUNT_UP = 16'h0004;
    localparam logic [15:0] CTRL_IRQ_EN   = 16'h0008;
    localparam logic [15:0] CTRL_START    = 16'h0010;

    logic        clock_16;
    logic        reset;
    logic        io_wr;
    logic [3:0]  io_addr;
    logic [15:0] io_wdata;
    logic [15:0] io_rdata;
    logic        irq;

    logic [31:0] rng_state = 32'h25e3;
    int unsigned cycle_cnt = 0;

    timer_top #(.NUM_TIMERS(NUM_TIMERS)) dut_i (
        .clock_16,
        .reset,
        .io_wr,
        .io_addr,
        .io_wdata,
        .io_rdata,
        .irq
    );

    initial begin
        clock_16 = 1'b0;
        forever #(CLK_PERIOD / 2) clock_16 = ~clock_16;
    end

    always @(posedge clock_16) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_now(input string msg);
        $display("error at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopped at the first failing check");
    endtask

    // registers and irq come out of reset cleared.
    assert property (@(posedge clock_16) reset |=> (!irq && io_rdata == 16'h0000))
        else fail_now("irq or read data not cleared by reset");

    // irq is the OR of the flags seen through IF.
    assert property (@(posedge clock_16) disable iff (reset)
        (io_addr == gba_timer_pkg::IF_ADDR) |-> (irq == (io_rdata[NUM_TIMERS-1:0] != 4'd0)))
        else fail_now("irq does not match the IF register");

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [15:0] r);
        rng_state = lcg_next(rng_state);
        r = rng_state[31:16]; // upper bits have the longer period.
    endtask

    function automatic logic [3:0] cnt_l(input int n);
        return 4'(2 * n);
    endfunction

    function automatic logic [3:0] cnt_h(input int n);
        return 4'(2 * n + 1);
    endfunction

    task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
        assert (got == exp) else fail_now($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else fail_now(what);
    endtask

    // write strobe for one cycle, captured on the second edge.
    task automatic bus_write(input logic [3:0] addr, input logic [15:0] data);
        @(posedge clock_16);
        io_wr    <= 1'b1;
        io_addr  <= addr;
        io_wdata <= data;
        @(posedge clock_16);
        io_wr    <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [15:0] data);
        @(posedge clock_16);
        io_wr   <= 1'b0;
        io_addr <= addr;
        @(negedge clock_16);
        data = io_rdata;
    endtask

    // polls IF once per cycle until a flag in mask is set.
    task automatic wait_flag(input logic [15:0] mask, input int max_cycles,
                             output int unsigned seen_at);
        logic [15:0] rd;
        int          n;
        n = 0;
        bus_read(gba_timer_pkg::IF_ADDR, rd);
        while ((rd & mask) == 16'h0000) begin
            n++;
            if (n > max_cycles) begin
                fail_now($sformatf("flag %h did not set within %0d cycles", mask, max_cycles));
            end
            bus_read(gba_timer_pkg::IF_ADDR, rd);
        end
        seen_at = cycle_cnt;
    endtask

    initial begin
        repeat (TEST_CYCLES + MARGIN_CYCLES) @(posedge clock_16);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $fatal(1, "simulation timed out");
    end

    initial begin
        logic [15:0] rd;
        logic [15:0] prev;
        logic [15:0] rnd;
        logic [15:0] reload;
        logic [15:0] exp;
        logic [3:0]  remaining;
        int unsigned t_prev;
        int unsigned t_now;
        int          diff;
        int          k;
        int          j;
        int          tmp;
        int          order [3];

        reset    <= 1'b1;
        io_wr    <= 1'b0;
        io_addr  <= 4'h0;
        io_wdata <= 16'h0000;
        repeat (RESET_CYCLES) @(posedge clock_16);
        reset <= 1'b0;

        // reset state.
        for (int a = 0; a < 16; a++) begin
            bus_read(4'(a), rd);
            check_eq(rd, 16'h0000, $sformatf("address %0d after reset", a));
        end
        check_true(irq == 1'b0, "irq high after reset");

        // free running at div_1 on channel 0.
        draw_random(rnd);
        reload = 16'hFFE0 | (rnd & 16'h000F);
        bus_write(cnt_l(0), reload);
        bus_write(cnt_h(0), CTRL_START | CTRL_IRQ_EN);
        bus_read(cnt_l(0), prev);
        check_eq(prev, reload, "timer 0 load on start");
        for (int i = 0; i < 40; i++) begin
            bus_read(cnt_l(0), rd);
            exp = (prev == 16'hFFFF) ? reload : prev + 16'd1;
            check_eq(rd, exp, "timer 0 successive reads");
            prev = rd;
        end
        bus_write(gba_timer_pkg::IF_ADDR, 16'h0001);
        wait_flag(16'h0001, 64, t_prev); // may be a set that beat the clear.
        bus_write(gba_timer_pkg::IF_ADDR, 16'h0001);
        wait_flag(16'h0001, 64, t_prev);
        bus_write(gba_timer_pkg::IF_ADDR, 16'h0001);
        for (int i = 0; i < 3; i++) begin
            wait_flag(16'h0001, 64, t_now);
            check_true(int'(t_now - t_prev) == 65536 - int'(reload),
                       $sformatf("overflow spacing %0d cycles, reload %h",
                                 t_now - t_prev, reload));
            bus_write(gba_timer_pkg::IF_ADDR, 16'h0001);
            t_prev = t_now;
        end
        bus_write(cnt_h(0), 16'h0000);
        bus_write(gba_timer_pkg::IF_ADDR, 16'h000F);

        // div_64 on channel 2, one step per 64 cycle window.
        draw_random(rnd);
        reload = rnd & 16'h7FFF;
        bus_write(cnt_l(2), reload);
        bus_write(cnt_h(2), CTRL_START | CTRL_DIV_64);
        bus_read(cnt_l(2), prev);
        t_prev = cycle_cnt;
        check_eq(prev, reload, "timer 2 load on start");
        for (int m = 0; m < WINDOWS; m++) begin
            repeat (63) @(posedge clock_16);
            bus_read(cnt_l(2), rd);
            check_eq(rd, prev + 16'd1, "timer 2 across a 64 cycle window");
            prev = rd;
        end
        // one more read off the window grid.
        draw_random(rnd);
        repeat (int'(rnd[5:0])) @(posedge clock_16);
        bus_read(cnt_l(2), rd);
        diff = int'(rd) - int'(reload) - int'(cycle_cnt - t_prev) / 64;
        check_true(diff >= -1 && diff <= 1, "timer 2 count drifted from reload plus windows");
        bus_write(cnt_h(2), 16'h0000);

        // cascade, channel 1 counts overflows of channel 0.
        draw_random(rnd);
        k = 2 + int'(rnd[1:0]);
        bus_write(cnt_l(1), 16'h0000);
        bus_write(cnt_h(1), CTRL_START | CTRL_COUNT_UP);
        bus_write(cnt_l(0), 16'hFFF0);
        // count_up on channel 0 must not stall it.
        bus_write(cnt_h(0), CTRL_START | CTRL_IRQ_EN | CTRL_COUNT_UP);
        for (int i = 0; i < k; i++) begin
            wait_flag(16'h0001, 64, t_now);
            bus_write(gba_timer_pkg::IF_ADDR, 16'h0001);
        end
        bus_write(cnt_h(0), 16'h0000);
        bus_read(cnt_l(1), rd);
        check_eq(rd, 16'(k), "timer 1 cascade count");
        repeat (48) @(posedge clock_16);
        bus_read(cnt_l(1), rd);
        check_eq(rd, 16'(k), "timer 1 after timer 0 stopped");
        bus_write(cnt_h(1), 16'h0000);
        bus_write(gba_timer_pkg::IF_ADDR, 16'h000F);

        // interrupts, channel 1 has no enable.
        for (int n = 0; n < NUM_TIMERS; n++) begin
            bus_write(cnt_l(n), 16'hFFF0);
        end
        bus_write(cnt_h(0), CTRL_START | CTRL_IRQ_EN);
        bus_write(cnt_h(1), CTRL_START);
        bus_write(cnt_h(2), CTRL_START | CTRL_IRQ_EN);
        bus_write(cnt_h(3), CTRL_START | CTRL_IRQ_EN);
        repeat (40) @(posedge clock_16);
        for (int n = 0; n < NUM_TIMERS; n++) begin
            bus_write(cnt_h(n), 16'h0000);
        end
        remaining = 4'b1101;
        bus_read(gba_timer_pkg::IF_ADDR, rd);
        check_eq(rd, {12'h000, remaining}, "IF after overflows");
        check_true(irq == 1'b1, "irq low with flags set");
        bus_write(gba_timer_pkg::IF_ADDR, 16'h0000);
        bus_read(gba_timer_pkg::IF_ADDR, rd);
        check_eq(rd, {12'h000, remaining}, "IF after writing zero");
        order = '{0, 2, 3};
        for (int i = 2; i > 0; i--) begin
            draw_random(rnd);
            j = int'(rnd[7:0]) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 3; i++) begin
            bus_write(gba_timer_pkg::IF_ADDR, 16'h0001 << order[i]);
            remaining = remaining & ~(4'b0001 << order[i]);
            bus_read(gba_timer_pkg::IF_ADDR, rd);
            check_eq(rd, {12'h000, remaining}, $sformatf("IF after clearing bit %0d", order[i]));
            check_true(irq == (remaining != 4'd0), "irq does not follow the flags");
        end

        // reload written while running, then a restart.
        bus_write(cnt_l(3), 16'hFFC0);
        bus_write(cnt_h(3), 16'h0000);
        bus_write(cnt_h(3), CTRL_START | CTRL_IRQ_EN);
        bus_read(cnt_l(3), rd);
        check_eq(rd, 16'hFFC0, "timer 3 load on start");
        bus_read(cnt_l(3), prev);
        draw_random(rnd);
        reload = 16'hFFE0 | (rnd & 16'h000F);
        bus_write(cnt_l(3), reload);
        bus_read(cnt_l(3), rd);
        check_eq(rd, prev + 16'd3, "timer 3 live count after reload write");
        wait_flag(16'h0008, 80, t_now);
        bus_read(cnt_l(3), rd);
        check_eq(rd, reload + 16'd1, "timer 3 count after overflow");
        draw_random(rnd);
        reload = rnd & 16'h7FFF;
        bus_write(cnt_l(3), reload);
        bus_write(cnt_h(3), 16'h0000);
        bus_write(cnt_h(3), CTRL_START | CTRL_IRQ_EN);
        bus_read(cnt_l(3), rd);
        check_eq(rd, reload, "timer 3 restart load");
        bus_write(cnt_h(3), 16'h0000);
        bus_write(gba_timer_pkg::IF_ADDR, 16'h000F);

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: timer_top.f
gba_timer_pkg.sv
timer_prescaler.sv
timer.sv
timer_regs.sv
timer_irq.sv
timer_top.sv
tb_timer_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_timer_top
FILELIST  := timer_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SOURCES   := $(shell cat $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
